// ==== hdl/uart_pkg.sv ====
// UART shared definitions
`default_nettype none

package uart_pkg;

	// --------------------------------------------------
	// line timing
	// --------------------------------------------------
	localparam int CLK_HZ        = 1_000_000;      // low clock keeps simulation short
	localparam int BAUD          = 100_000;
	localparam int BAUD_DIV      = CLK_HZ / BAUD;  // clocks per bit, 10
	localparam int BAUD_DIV_HALF = BAUD_DIV / 2;   // rx counts in half bits

	// receive buffer, power of two only
	localparam int FIFO_DEPTH = 8;

	// --------------------------------------------------
	// types
	// --------------------------------------------------
	typedef logic [7:0] uart_byte_t;   // one data byte
	typedef logic [15:0] baud_cnt_t;   // bit period counters

	// extra msb separates full from empty
	typedef logic [$clog2(FIFO_DEPTH):0] fifo_ptr_t;

	typedef enum logic [1:0] {
		TX_IDLE,   // line high, waiting for tx_start
		TX_START,  // start bit, line low
		TX_DATA,   // eight data bits lsb first
		TX_STOP    // one stop bit, line high
	} tx_state_e;

	// receiver result, done and err are one cycle strobes
	typedef struct packed {
		uart_byte_t data;  // valid while done is high
		logic       done;  // good stop bit
		logic       err;   // stop bit sampled low
	} rx_event_t;

endpackage

`default_nettype wire

// ==== hdl/static_delay.sv ====
// Register delay line
`timescale 1ns/1ps
`default_nettype none

module static_delay #(
	parameter int LENGTH = 2,  // number of register stages
	parameter int WIDTH  = 1   // bits per stage
) (
	input  logic             clk,
	input  logic             nrst,
	input  logic [WIDTH-1:0] in,
	output logic [WIDTH-1:0] out
);

	// stage 0 takes the input, last stage drives out
	logic [LENGTH-1:0][WIDTH-1:0] stages;

	always_ff @(posedge clk) begin
		if (!nrst) begin
			stages <= '1;  // idle uart line reads high
		end else begin
			stages[0] <= in;
			for (int i = 1; i < LENGTH; i++) begin
				stages[i] <= stages[i-1];  // shift one stage per clock
			end
		end
	end

	// as rxd synchronizer the first stage may go metastable,
	// the second one gives it a full cycle to settle
	assign out = stages[LENGTH-1];

endmodule

`default_nettype wire

// ==== hdl/uart_rx.sv ====
// UART receiver
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
	input  logic                clk,
	input  logic                nrst,
	input  logic                rxd,      // asynchronous line input
	output logic                rx_busy,  // frame in progress
	output uart_pkg::rx_event_t rx_evt
);

	// --------------------------------------------------
	// synchronizer and start edge
	// --------------------------------------------------
	logic s_rxd;         // rxd after two flops
	logic rxd_prev;      // s_rxd one cycle older
	logic start_strobe;  // registered falling edge

	static_delay #(
		.LENGTH(2),
		.WIDTH (1)
	) u_sync (
		.clk (clk),
		.nrst(nrst),
		.in  (rxd),
		.out (s_rxd)
	);

	always_ff @(posedge clk) begin
		if (!nrst) begin
			rxd_prev     <= 1'b1;  // idle line is high
			start_strobe <= 1'b0;
		end else begin
			rxd_prev     <= s_rxd;
			start_strobe <= rxd_prev & ~s_rxd;  // high to low transition
		end
	end

	// --------------------------------------------------
	// sample timing and shift register
	// --------------------------------------------------
	uart_pkg::baud_cnt_t sample_cnt;  // counts down in half bit units
	uart_pkg::uart_byte_t rx_data;    // data bits with the msb entered last
	logic rx_marker;                  // bottom of the 9 bit shifter
	logic do_sample;

	// {rx_data, rx_marker} shifts right, a single 1 loaded at the top
	// walks down and reaches rx_marker after the eighth data bit
	assign do_sample = rx_busy && (sample_cnt == '0);

	always_ff @(posedge clk) begin
		if (!nrst) begin
			rx_busy    <= 1'b0;
			sample_cnt <= '0;
		end else if (!rx_busy) begin
			if (start_strobe) begin
				// 1.5 bits to the middle of data bit 0
				sample_cnt <= uart_pkg::baud_cnt_t'(uart_pkg::BAUD_DIV_HALF * 3 - 1);
				rx_busy    <= 1'b1;
			end
		end else begin
			if (sample_cnt == '0) begin
				// one full bit to the next middle
				sample_cnt <= uart_pkg::baud_cnt_t'(uart_pkg::BAUD_DIV_HALF * 2 - 1);
			end else begin
				sample_cnt <= sample_cnt - 1'b1;
			end
			if (do_sample && rx_marker) begin
				rx_busy <= 1'b0;  // stop bit sample ends the frame
			end
		end
	end

	// marker shifter loaded on the start strobe
	always_ff @(posedge clk) begin
		if (!rx_busy && start_strobe) begin
			{rx_data, rx_marker} <= 9'b1_0000_0000;  // marker at the top
		end else if (do_sample && !rx_marker) begin
			{rx_data, rx_marker} <= {s_rxd, rx_data};  // line bit in from the top
		end
	end

	// --------------------------------------------------
	// stop bit check
	// --------------------------------------------------
	// strobes coincide with busy falling
	assign rx_evt = '{
		data: rx_data,
		done: do_sample & rx_marker & s_rxd,
		err:  do_sample & rx_marker & ~s_rxd
	};

endmodule

`default_nettype wire

// ==== hdl/uart_tx.sv ====
// UART transmitter
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input  logic                 clk,
	input  logic                 nrst,
	input  uart_pkg::uart_byte_t tx_data,   // captured with tx_start
	input  logic                 tx_start,  // one cycle request
	output logic                 tx_busy,
	output logic                 txd        // serial out, idles high
);

	uart_pkg::tx_state_e state;
	uart_pkg::baud_cnt_t bit_cnt;    // cycles left in current bit
	logic [2:0] bit_idx;             // data bit being sent
	uart_pkg::uart_byte_t tx_shift;  // remaining data bits, lsb next
	logic bit_end;                   // last cycle of current bit

	assign bit_end = (bit_cnt == '0);
	assign tx_busy = (state != uart_pkg::TX_IDLE);  // requests ignored when high

	// --------------------------------------------------
	// state machine and line register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nrst) begin
			state   <= uart_pkg::TX_IDLE;
			bit_cnt <= '0;
			bit_idx <= '0;
			txd     <= 1'b1;
		end else begin
			case (state)
				uart_pkg::TX_IDLE: begin
					if (tx_start) begin
						state   <= uart_pkg::TX_START;
						txd     <= 1'b0;  // start bit on the accepting edge
						bit_cnt <= uart_pkg::baud_cnt_t'(uart_pkg::BAUD_DIV - 1);
					end
				end
				uart_pkg::TX_START: begin
					if (bit_end) begin
						state   <= uart_pkg::TX_DATA;
						txd     <= tx_shift[0];  // data bit 0
						bit_idx <= '0;
						bit_cnt <= uart_pkg::baud_cnt_t'(uart_pkg::BAUD_DIV - 1);
					end else begin
						bit_cnt <= bit_cnt - 1'b1;
					end
				end
				uart_pkg::TX_DATA: begin
					if (bit_end) begin
						bit_cnt <= uart_pkg::baud_cnt_t'(uart_pkg::BAUD_DIV - 1);
						if (bit_idx == 3'd7) begin
							state <= uart_pkg::TX_STOP;
							txd   <= 1'b1;  // stop bit
						end else begin
							bit_idx <= bit_idx + 1'b1;
							txd     <= tx_shift[1];  // next bit, shifter moves below
						end
					end else begin
						bit_cnt <= bit_cnt - 1'b1;
					end
				end
				uart_pkg::TX_STOP: begin
					if (bit_end) begin
						state <= uart_pkg::TX_IDLE;  // 10 bits, 100 clocks in total
					end else begin
						bit_cnt <= bit_cnt - 1'b1;
					end
				end
				default: begin
					state <= uart_pkg::TX_IDLE;
					txd   <= 1'b1;
				end
			endcase
		end
	end

	// --------------------------------------------------
	// data shifter
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (state == uart_pkg::TX_IDLE && tx_start) begin
			tx_shift <= tx_data;  // capture in the accepting cycle
		end else if (state == uart_pkg::TX_DATA && bit_end) begin
			tx_shift <= {1'b0, tx_shift[7:1]};  // lsb first
		end
	end

endmodule

`default_nettype wire

// ==== hdl/rx_fifo.sv ====
// Receive byte FIFO
`timescale 1ns/1ps
`default_nettype none

module rx_fifo (
	input  logic                 clk,
	input  logic                 nrst,
	input  uart_pkg::uart_byte_t wr_data,
	input  logic                 wr_en,     // receiver done strobe
	input  logic                 rd_en,     // pop oldest entry
	output uart_pkg::uart_byte_t rd_data,   // show ahead, oldest entry
	output logic                 rd_valid,  // not empty
	output logic                 overflow   // one cycle, byte dropped
);

	// --------------------------------------------------
	// storage and pointers
	// --------------------------------------------------
	uart_pkg::uart_byte_t mem [uart_pkg::FIFO_DEPTH];
	uart_pkg::fifo_ptr_t wr_ptr;
	uart_pkg::fifo_ptr_t rd_ptr;
	logic [$clog2(uart_pkg::FIFO_DEPTH)-1:0] wr_addr;  // pointer without wrap bit
	logic [$clog2(uart_pkg::FIFO_DEPTH)-1:0] rd_addr;
	logic empty;
	logic full;
	logic do_write;
	logic do_read;

	assign wr_addr = wr_ptr[$clog2(uart_pkg::FIFO_DEPTH)-1:0];
	assign rd_addr = rd_ptr[$clog2(uart_pkg::FIFO_DEPTH)-1:0];

	// same address, wrap bits equal means empty, different means full
	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_addr == rd_addr) &&
	               (wr_ptr[$clog2(uart_pkg::FIFO_DEPTH)] != rd_ptr[$clog2(uart_pkg::FIFO_DEPTH)]);

	assign do_read  = rd_en && !empty;             // pop on empty is a no-op
	assign do_write = wr_en && (!full || do_read); // a pop frees the slot

	always_ff @(posedge clk) begin
		if (!nrst) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			overflow <= wr_en && !do_write;  // line cannot be stalled, byte lost
		end
	end

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// --------------------------------------------------
	// read side
	// --------------------------------------------------
	assign rd_data  = mem[rd_addr];  // combinational read
	assign rd_valid = !empty;

endmodule

`default_nettype wire

// ==== hdl/uart_core.sv ====
// UART core top level
`timescale 1ns/1ps
`default_nettype none

module uart_core (
	input  logic                 clk,
	input  logic                 nrst,
	// transmit host side
	input  uart_pkg::uart_byte_t tx_data,
	input  logic                 tx_start,
	output logic                 tx_busy,
	// serial line
	output logic                 txd,
	input  logic                 rxd,
	// receive host side
	output logic                 rx_busy,
	output logic                 rx_err,       // bad stop bit strobe
	output logic                 rx_overflow,  // byte dropped, fifo full
	input  logic                 rd_en,
	output uart_pkg::uart_byte_t rd_data,
	output logic                 rd_valid
);

	uart_pkg::rx_event_t rx_evt;  // receiver result bundle

	uart_tx u_tx (
		.clk     (clk),
		.nrst    (nrst),
		.tx_data (tx_data),
		.tx_start(tx_start),
		.tx_busy (tx_busy),
		.txd     (txd)
	);

	uart_rx u_rx (
		.clk    (clk),
		.nrst   (nrst),
		.rxd    (rxd),
		.rx_busy(rx_busy),
		.rx_evt (rx_evt)
	);

	// only good frames reach the fifo
	rx_fifo u_fifo (
		.clk     (clk),
		.nrst    (nrst),
		.wr_data (rx_evt.data),
		.wr_en   (rx_evt.done),
		.rd_en   (rd_en),
		.rd_data (rd_data),
		.rd_valid(rd_valid),
		.overflow(rx_overflow)
	);

	assign rx_err = rx_evt.err;  // framing error goes straight out

endmodule

`default_nettype wire

// ==== dv/uart_core_assertions.sv ====
// UART core assertions
`timescale 1ns/1ps
`default_nettype none

module uart_core_assertions (
	input logic                clk,
	input logic                nrst,
	input logic                tx_start,
	input logic                tx_busy,
	input logic                txd,
	input logic                rx_err,
	input uart_pkg::rx_event_t rx_evt,   // done is the fifo write
	input logic                rd_valid
);

	// busy cycle count starting at 0 in the first busy cycle
	int busy_len;
	int fail_cnt;  // failed assertions so far

	always_ff @(posedge clk) begin
		if (!nrst || !tx_busy) begin
			busy_len <= 0;
		end else begin
			busy_len <= busy_len + 1;
		end
	end

	// --------------------------------------------------
	// receive side
	// --------------------------------------------------
	rx_err_no_write: assert property (@(posedge clk) disable iff (!nrst)
		!(rx_err && rx_evt.done))
		else begin
			$error("rx_err and fifo write in the same cycle");
			fail_cnt++;
		end

	rd_valid_after_reset: assert property (@(posedge clk)
		!nrst |=> !rd_valid)
		else begin
			$error("rd_valid high in the cycle after reset");
			fail_cnt++;
		end

	// --------------------------------------------------
	// transmit side
	// --------------------------------------------------
	// txd only moves on the edge that ends each bit
	tx_start_ignored: assert property (@(posedge clk) disable iff (!nrst)
		(tx_start && tx_busy && (busy_len % uart_pkg::BAUD_DIV) != uart_pkg::BAUD_DIV - 1)
		|=> ($stable(txd) && tx_busy))
		else begin
			$error("tx_start while busy changed txd or tx_busy");
			fail_cnt++;
		end

	txd_idle_high: assert property (@(posedge clk) disable iff (!nrst)
		!tx_busy |-> txd)
		else begin
			$error("txd low while tx_busy is low");
			fail_cnt++;
		end

endmodule

bind uart_core uart_core_assertions u_assertions (
	.clk     (clk),
	.nrst    (nrst),
	.tx_start(tx_start),
	.tx_busy (tx_busy),
	.txd     (txd),
	.rx_err  (rx_err),
	.rx_evt  (rx_evt),
	.rd_valid(rd_valid)
);

`default_nettype wire

// ==== dv/uart_core_tb.sv ====
// UART core testbench
`timescale 1ns/1ps
`default_nettype none

module uart_core_tb;

	// --------------------------------------------------
	// DUT signals
	// --------------------------------------------------
	logic clk = 1'b0;
	logic nrst;
	uart_pkg::uart_byte_t tx_data;
	logic tx_start;
	logic tx_busy;
	logic txd;
	logic rxd_drv;   // line level from the frame driver
	logic loopback;  // 1 ties txd back to rxd
	logic rxd_line;
	logic rx_busy;
	logic rx_err;
	logic rx_overflow;
	logic rd_en;
	uart_pkg::uart_byte_t rd_data;
	logic rd_valid;

	// --------------------------------------------------
	// model and counters
	// --------------------------------------------------
	integer seed;
	uart_pkg::uart_byte_t model_q[$];  // bytes the fifo should hold in arrival order
	int exp_ovf;     // good frames a full fifo must drop
	int err_seen;    // rx_err pulses
	int ovf_seen;    // rx_overflow pulses
	int checks;
	int mismatches;
	int timeouts;

	assign rxd_line = loopback ? txd : rxd_drv;

	uart_core u_dut (
		.clk        (clk),
		.nrst       (nrst),
		.tx_data    (tx_data),
		.tx_start   (tx_start),
		.tx_busy    (tx_busy),
		.txd        (txd),
		.rxd        (rxd_line),
		.rx_busy    (rx_busy),
		.rx_err     (rx_err),
		.rx_overflow(rx_overflow),
		.rd_en      (rd_en),
		.rd_data    (rd_data),
		.rd_valid   (rd_valid)
	);

	initial begin
		forever #5 clk = ~clk;  // 10 ns period
	end

	// each one cycle strobe is seen at exactly one falling edge
	always @(negedge clk) begin
		if (nrst) begin
			if (rx_err)
				err_seen++;
			if (rx_overflow)
				ovf_seen++;
		end
	end

	function automatic uart_pkg::uart_byte_t random_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	function automatic int random_gap();  // 0 to 3
		logic [31:0] r;
		r = $random(seed);
		return int'(r[1:0]);
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			mismatches++;
			$display("FAIL t=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
		end
	endtask

	// --------------------------------------------------
	// line driver and monitor
	// --------------------------------------------------
	task automatic idle_bits(input int n);
		rxd_drv = 1'b1;
		repeat (n * uart_pkg::BAUD_DIV) @(negedge clk);
	endtask

	task automatic send_frame(input uart_pkg::uart_byte_t b, input logic stop);
		rxd_drv = 1'b0;  // start bit
		repeat (uart_pkg::BAUD_DIV) @(negedge clk);
		for (int i = 0; i < 8; i++) begin
			rxd_drv = b[i];  // lsb first
			repeat (uart_pkg::BAUD_DIV) @(negedge clk);
		end
		rxd_drv = stop;
		repeat (uart_pkg::BAUD_DIV) @(negedge clk);
		rxd_drv = 1'b1;
	endtask

	// decode one frame from txd sampled near each bit middle
	task automatic receive_txd(output uart_pkg::uart_byte_t b, output logic stop,
			output bit ok);
		int wait_cnt;
		wait_cnt = 0;
		b        = '0;
		stop     = 1'b0;
		ok       = 1'b0;
		do begin
			@(negedge clk);
			wait_cnt++;
		end while (txd && wait_cnt < 3 * uart_pkg::BAUD_DIV);
		if (txd) begin
			timeouts++;
			$display("timeout: no start bit on txd after %0d cycles", wait_cnt);
		end else begin
			repeat (uart_pkg::BAUD_DIV / 2 - 1) @(negedge clk);
			check_value("txd start bit", 0, txd);
			for (int i = 0; i < 8; i++) begin
				repeat (uart_pkg::BAUD_DIV) @(negedge clk);
				b[i] = txd;
			end
			repeat (uart_pkg::BAUD_DIV) @(negedge clk);
			stop = txd;
			ok   = 1'b1;
		end
	endtask

	// --------------------------------------------------
	// host side
	// --------------------------------------------------
	// request one byte, optionally poke tx_start mid frame, wait for idle
	task automatic transmit_byte(input uart_pkg::uart_byte_t b, input bit collide);
		int busy_cnt;
		busy_cnt = 0;
		tx_data  = b;
		tx_start = 1'b1;
		do begin
			@(negedge clk);
			tx_start = collide && (busy_cnt == 3 * uart_pkg::BAUD_DIV);
			if (tx_start)
				tx_data = ~b;  // must be ignored
			if (tx_busy)
				busy_cnt++;
		end while (tx_busy && busy_cnt < 11 * uart_pkg::BAUD_DIV);
		tx_start = 1'b0;
		if (tx_busy) begin
			timeouts++;
			$display("timeout: tx_busy still high after %0d cycles", busy_cnt);
		end else begin
			check_value("tx_busy cycles", 10 * uart_pkg::BAUD_DIV, busy_cnt);
		end
	endtask

	task automatic model_push(input uart_pkg::uart_byte_t b);
		if (model_q.size() < uart_pkg::FIFO_DEPTH)
			model_q.push_back(b);
		else
			exp_ovf++;  // full fifo drops the byte
	endtask

	task automatic pop_and_compare();
		uart_pkg::uart_byte_t exp_byte;
		int wait_cnt;
		wait_cnt = 0;
		while (!rd_valid && wait_cnt < 2 * uart_pkg::BAUD_DIV) begin
			@(negedge clk);
			wait_cnt++;
		end
		if (model_q.size() == 0) begin
			mismatches++;
			$display("model queue empty when a received byte was expected");
		end else begin
			exp_byte = model_q.pop_front();
			if (!rd_valid) begin
				timeouts++;
				$display("timeout: rd_valid stayed low, byte %0h never arrived", exp_byte);
			end else begin
				check_value("rd_data", exp_byte, rd_data);
				rd_en = 1'b1;
				@(negedge clk);
				rd_en = 1'b0;
			end
		end
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin
		uart_pkg::uart_byte_t b;
		uart_pkg::uart_byte_t got;
		logic stop;
		bit ok;
		int bad_sent;
		int err_base;
		int ovf_base;

		seed     = 32'hb8b0;
		nrst     = 1'b0;
		tx_data  = '0;
		tx_start = 1'b0;
		rxd_drv  = 1'b1;
		loopback = 1'b0;
		rd_en    = 1'b0;
		exp_ovf  = 0;
		repeat (4) @(negedge clk);
		nrst = 1'b1;
		@(negedge clk);
		check_value("tx_busy", 0, tx_busy);
		check_value("txd", 1, txd);
		check_value("rx_busy", 0, rx_busy);
		check_value("rx_err", 0, rx_err);
		check_value("rx_overflow", 0, rx_overflow);
		check_value("rd_valid", 0, rd_valid);

		// transmit with the monitor running alongside the request
		for (int i = 0; i < 20; i++) begin
			b = random_byte();
			fork
				transmit_byte(b, random_gap() < 2);
				receive_txd(got, stop, ok);
			join
			if (ok) begin
				check_value("txd data", b, got);
				check_value("txd stop bit", 1, stop);
			end
		end

		// receive with framing errors mixed in
		bad_sent = 0;
		err_base = err_seen;
		for (int i = 0; i < 30; i++) begin
			if (random_gap() == 0) begin
				send_frame(random_byte(), 1'b0);
				bad_sent++;
				idle_bits(1);  // line high again before the next start
				check_value("rd_valid", 0, rd_valid);
			end
			b = random_byte();
			send_frame(b, 1'b1);
			model_push(b);
			pop_and_compare();
			idle_bits(random_gap());
		end
		check_value("rx_err pulses", bad_sent, err_seen - err_base);

		// back to back frames with no pops overflow the fifo
		ovf_base = ovf_seen;
		for (int i = 0; i < 10; i++) begin
			b = random_byte();
			send_frame(b, 1'b1);
			model_push(b);
		end
		idle_bits(1);
		check_value("rx_overflow pulses", exp_ovf, ovf_seen - ovf_base);
		while (model_q.size() > 0)
			pop_and_compare();
		@(negedge clk);
		check_value("rd_valid", 0, rd_valid);

		// loopback txd to rxd
		loopback = 1'b1;
		for (int i = 0; i < 10; i++) begin
			b = random_byte();
			transmit_byte(b, 1'b0);
			model_push(b);
			pop_and_compare();
		end
		loopback = 1'b0;

		$display("checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
			checks, mismatches, timeouts, u_dut.u_assertions.fail_cnt);
		if (mismatches == 0 && timeouts == 0 && u_dut.u_assertions.fail_cnt == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== uart_core.f ====
hdl/uart_pkg.sv
hdl/static_delay.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/rx_fifo.sv
hdl/uart_core.sv
dv/uart_core_assertions.sv
dv/uart_core_tb.sv

// ==== Makefile ====
TOP = uart_core_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, search sim.log for the pass line"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal -f uart_core.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Simulation completed successfully" sim.log; then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
